//--- hw/rv_isa_pkg.sv
// RV32 ISA definitions for the execute stage
// data and register widths, operation classes and per-unit op codes

package rv_isa_pkg;

    // data path and register file geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xdata_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // instruction size in bytes, gives the link value pc+4
    localparam xdata_t ILEN_BYTES = 32'd4;

    // shift-add multiplier, one partial product per step
    localparam int MUL_STEPS = 32;
    localparam int MUL_CNT_W = $clog2(MUL_STEPS + 1);

    // which unit executes the instruction
    typedef enum logic [1:0] {
        CLS_ALU = 2'd0,
        CLS_BRU = 2'd1,
        CLS_MUL = 2'd2
    } op_class_e;

    // integer ALU ops, register forms plus lui/auipc
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_LUI   = 4'd10,
        ALU_AUIPC = 4'd11
    } alu_op_e;

    // conditional branches and the two jumps
    typedef enum logic [2:0] {
        BRU_BEQ  = 3'd0,
        BRU_BNE  = 3'd1,
        BRU_BLT  = 3'd2,
        BRU_BGE  = 3'd3,
        BRU_BLTU = 3'd4,
        BRU_BGEU = 3'd5,
        BRU_JAL  = 3'd6,
        BRU_JALR = 3'd7
    } bru_op_e;

    // M extension multiplies
    typedef enum logic [1:0] {
        MUL_MUL    = 2'd0,
        MUL_MULH   = 2'd1,
        MUL_MULHSU = 2'd2,
        MUL_MULHU  = 2'd3
    } mul_op_e;

endpackage

//--- hw/exu_pkg.sv
// Execute stage transport types
// issue bundle from upstream, writeback to the register file, fetch redirect

package exu_pkg;

    import rv_isa_pkg::*;

    // op field is shared by all classes, read according to cls
    localparam int EXU_OP_W = 4;

    // one issued instruction, already classified
    typedef struct packed {
        logic                valid;
        op_class_e           cls;
        logic [EXU_OP_W-1:0] op;
        xdata_t              rs1;
        xdata_t              rs2;
        xdata_t              imm;
        xdata_t              pc;
        reg_addr_t           rd;
    } exu_issue_t;

    // register file write port
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xdata_t    wdata;
    } exu_wb_t;

    // redirect towards fetch
    typedef struct packed {
        logic   flag;
        xdata_t addr;
    } exu_jump_t;

endpackage

//--- hw/exu_alu.sv
// Integer ALU
// single-cycle RV32 arithmetic, logic, shifts and compares; also forms the
// pc+4 link value so that jumps reuse the same writeback path

`timescale 1ns/1ps

module exu_alu (
    input  logic                req_i,
    input  logic                link_i,
    input  exu_pkg::exu_issue_t issue_i,
    output exu_pkg::exu_wb_t    wb_o
);

    import rv_isa_pkg::*;
    import exu_pkg::*;

    alu_op_e alu_op;
    xdata_t  op_b;
    xdata_t  alu_res;
    logic    [4:0] shamt;

    assign alu_op = alu_op_e'(issue_i.op);

    // upper-immediate forms take imm, everything else is register-register
    assign op_b  = (alu_op == ALU_LUI || alu_op == ALU_AUIPC) ? issue_i.imm : issue_i.rs2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:   alu_res = issue_i.rs1 + op_b;
            ALU_SUB:   alu_res = issue_i.rs1 - op_b;
            ALU_SLL:   alu_res = issue_i.rs1 << shamt;
            ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(issue_i.rs1) < $signed(op_b)};
            ALU_SLTU:  alu_res = {{(XLEN-1){1'b0}}, issue_i.rs1 < op_b};
            ALU_XOR:   alu_res = issue_i.rs1 ^ op_b;
            ALU_SRL:   alu_res = issue_i.rs1 >> shamt;
            ALU_SRA:   alu_res = $signed(issue_i.rs1) >>> shamt;
            ALU_OR:    alu_res = issue_i.rs1 | op_b;
            ALU_AND:   alu_res = issue_i.rs1 & op_b;
            // imm already holds the shifted upper bits
            ALU_LUI:   alu_res = op_b;
            ALU_AUIPC: alu_res = issue_i.pc + op_b;
            default:   alu_res = '0;
        endcase
    end

    // jal/jalr write the return address instead of an ALU result
    assign wb_o.we    = req_i | link_i;
    assign wb_o.waddr = issue_i.rd;
    assign wb_o.wdata = link_i ? (issue_i.pc + ILEN_BYTES) : alu_res;

endmodule

//--- hw/exu_bru.sv
// Branch unit
// evaluates the RV32 branch conditions and computes the redirect target
// for branches, jal and jalr

`timescale 1ns/1ps

module exu_bru (
    input  logic                req_i,
    input  exu_pkg::exu_issue_t issue_i,
    output exu_pkg::exu_jump_t  jump_o
);

    import rv_isa_pkg::*;
    import exu_pkg::*;

    bru_op_e bru_op;
    logic    op_eq;
    logic    op_lt;
    logic    op_ltu;
    logic    taken;
    xdata_t  pc_target;
    xdata_t  reg_target;

    assign bru_op = bru_op_e'(issue_i.op[2:0]);

    // comparisons on the register operands
    assign op_eq  = (issue_i.rs1 == issue_i.rs2);
    assign op_lt  = ($signed(issue_i.rs1) < $signed(issue_i.rs2));
    assign op_ltu = (issue_i.rs1 < issue_i.rs2);

    always_comb begin
        case (bru_op)
            BRU_BEQ:  taken = op_eq;
            BRU_BNE:  taken = ~op_eq;
            BRU_BLT:  taken = op_lt;
            BRU_BGE:  taken = ~op_lt;
            BRU_BLTU: taken = op_ltu;
            BRU_BGEU: taken = ~op_ltu;
            default:  taken = 1'b1;
        endcase
    end

    assign pc_target  = issue_i.pc + issue_i.imm;
    // jalr drops the lsb of rs1+imm
    assign reg_target = (issue_i.rs1 + issue_i.imm) & ~xdata_t'(1);

    assign jump_o.flag = req_i & taken;
    assign jump_o.addr = (bru_op == BRU_JALR) ? reg_target : pc_target;

    // relies on upstream handing over an aligned pc and an even imm
    a_target_align: assert final (!jump_o.flag || !jump_o.addr[0])
        else $error("branch target not 2-byte aligned");

endmodule

//--- hw/exu_mul.sv
// Multicycle multiplier
// shift-add on operand magnitudes with a sign fix-up at the end;
// returns the low word for mul and the high word for mulh/mulhsu/mulhu

`timescale 1ns/1ps

module exu_mul (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                start_i,
    input  exu_pkg::exu_issue_t issue_i,
    output logic                busy_o,
    output exu_pkg::exu_wb_t    wb_o
);

    import rv_isa_pkg::*;
    import exu_pkg::*;

    mul_op_e               mul_op;
    logic                  a_neg;
    logic                  b_neg;
    xdata_t                a_mag;
    xdata_t                b_mag;
    logic                  step_done;
    logic [2*XLEN-1:0]     acc_next;

    logic                  busy_q;
    logic                  res_vld_q;
    logic [MUL_CNT_W-1:0]  step_q;
    logic [2*XLEN-1:0]     acc_q;
    logic [2*XLEN-1:0]     mcand_q;
    xdata_t                mplier_q;
    logic                  neg_q;
    logic                  hi_sel_q;
    reg_addr_t             rd_q;

    assign mul_op = mul_op_e'(issue_i.op[1:0]);

    // rs1 is signed for mulh and mulhsu, rs2 only for mulh
    assign a_neg = (mul_op == MUL_MULH || mul_op == MUL_MULHSU) && issue_i.rs1[XLEN-1];
    assign b_neg = (mul_op == MUL_MULH) && issue_i.rs2[XLEN-1];
    assign a_mag = a_neg ? -issue_i.rs1 : issue_i.rs1;
    assign b_mag = b_neg ? -issue_i.rs2 : issue_i.rs2;

    assign step_done = (step_q == MUL_CNT_W'(MUL_STEPS));
    assign acc_next  = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

    // start -> MUL_STEPS steps -> one fix-up edge -> result cycle -> idle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q    <= 1'b0;
            res_vld_q <= 1'b0;
            step_q    <= '0;
        end else if (start_i) begin
            busy_q    <= 1'b1;
            res_vld_q <= 1'b0;
            step_q    <= '0;
        end else if (res_vld_q) begin
            busy_q    <= 1'b0;
            res_vld_q <= 1'b0;
        end else if (busy_q) begin
            if (step_done) begin
                res_vld_q <= 1'b1;
            end else begin
                step_q <= step_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q    <= '0;
            mcand_q  <= {{XLEN{1'b0}}, a_mag};
            mplier_q <= b_mag;
            neg_q    <= a_neg ^ b_neg;
            hi_sel_q <= (mul_op != MUL_MUL);
            rd_q     <= issue_i.rd;
        end else if (busy_q && !res_vld_q) begin
            if (step_done) begin
                // restore the sign of the full 64-bit product
                acc_q <= neg_q ? -acc_q : acc_q;
            end else begin
                acc_q    <= acc_next;
                mcand_q  <= mcand_q << 1;
                mplier_q <= mplier_q >> 1;
            end
        end
    end

    assign busy_o      = busy_q;
    assign wb_o.we     = res_vld_q;
    assign wb_o.waddr  = rd_q;
    assign wb_o.wdata  = hi_sel_q ? acc_q[2*XLEN-1:XLEN] : acc_q[XLEN-1:0];

    // top level must hold off new multiplies while one is running
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset_i)
        start_i |-> !busy_o);

    a_wb_single: assert property (@(posedge clk) disable iff (reset_i)
        wb_o.we |=> !wb_o.we);

endmodule

//--- hw/exu_top.sv
// RV32 execute stage
// dispatches one issue per cycle to ALU, branch unit or multiplier, merges
// their writebacks and applies the interrupt redirect

`timescale 1ns/1ps

module exu_top (
    input  logic                 clk,
    input  logic                 reset_i,
    input  exu_pkg::exu_issue_t  issue_i,
    input  logic                 int_assert_i,
    input  rv_isa_pkg::xdata_t   int_addr_i,
    output exu_pkg::exu_wb_t     wb_o,
    output exu_pkg::exu_jump_t   jump_o,
    output logic                 hold_o
);

    import rv_isa_pkg::*;
    import exu_pkg::*;

    logic      issue_ok;
    logic      alu_req;
    logic      bru_req;
    logic      link_req;
    logic      mul_start;
    logic      mul_busy;
    bru_op_e   bru_op;
    exu_wb_t   alu_wb;
    exu_wb_t   mul_wb;
    exu_wb_t   wb_sel;
    exu_jump_t bru_jump;

    // issue is ignored while the multiplier holds the pipe
    assign issue_ok = issue_i.valid & ~mul_busy;
    assign bru_op   = bru_op_e'(issue_i.op[2:0]);

    assign alu_req   = issue_ok && (issue_i.cls == CLS_ALU);
    assign bru_req   = issue_ok && (issue_i.cls == CLS_BRU);
    assign link_req  = bru_req && (bru_op == BRU_JAL || bru_op == BRU_JALR);
    assign mul_start = issue_ok && (issue_i.cls == CLS_MUL) && !int_assert_i;

    exu_alu u_alu (
        .req_i   (alu_req),
        .link_i  (link_req),
        .issue_i (issue_i),
        .wb_o    (alu_wb)
    );

    exu_bru u_bru (
        .req_i   (bru_req),
        .issue_i (issue_i),
        .jump_o  (bru_jump)
    );

    exu_mul u_mul (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (mul_start),
        .issue_i (issue_i),
        .busy_o  (mul_busy),
        .wb_o    (mul_wb)
    );

    assign hold_o = mul_busy;

    // multiply result wins, then the ALU/link path
    assign wb_sel = mul_wb.we ? mul_wb : alu_wb;

    assign wb_o.we    = wb_sel.we & ~int_assert_i;
    assign wb_o.waddr = wb_sel.waddr;
    assign wb_o.wdata = wb_sel.wdata;

    // interrupt takes the fetch redirect
    assign jump_o.flag = bru_jump.flag | int_assert_i;
    assign jump_o.addr = int_assert_i ? int_addr_i : bru_jump.addr;

endmodule

//--- verif/exu_tb.sv
// Testbench for the RV32 execute stage
// applies a table of ALU, branch, multiply and interrupt cases and checks
// writeback, redirect and hold against the RV32 results

`timescale 1ns/1ps

module exu_tb;

    import rv_isa_pkg::*;
    import exu_pkg::*;

    // one table row: stimulus plus expected outputs
    typedef struct packed {
        logic       is_mul;
        exu_issue_t issue;
        logic       irq;
        xdata_t     irq_addr;
        exu_wb_t    exp_wb;
        exu_jump_t  exp_jump;
    } tb_entry_t;

    logic       clk;
    logic       reset_i;
    exu_issue_t issue_i;
    logic       int_assert_i;
    xdata_t     int_addr_i;
    exu_wb_t    wb_o;
    exu_jump_t  jump_o;
    logic       hold_o;

    tb_entry_t   table_q[$];
    logic [31:0] rng_state      = 32'h7a95319f;
    int unsigned n_checks       = 0;
    int unsigned n_errors       = 0;
    int unsigned cycle_cnt      = 0;
    int unsigned timeout_cycles = 0;

    exu_top u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .issue_i      (issue_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .wb_o         (wb_o),
        .jump_o       (jump_o),
        .hold_o       (hold_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // full 64-bit product, each operand extended by the signedness of the op
    function automatic xdata_t mul_result(input mul_op_e op, input xdata_t a, input xdata_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        ea   = (op == MUL_MULH || op == MUL_MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
        eb   = (op == MUL_MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        prod = ea * eb;
        return (op == MUL_MUL) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic exu_issue_t make_issue(input op_class_e cls, input logic [3:0] op,
                                              input xdata_t rs1, input xdata_t rs2,
                                              input xdata_t imm, input xdata_t pc,
                                              input reg_addr_t rd);
        exu_issue_t iss;
        iss.valid = 1'b1;
        iss.cls   = cls;
        iss.op    = op;
        iss.rs1   = rs1;
        iss.rs2   = rs2;
        iss.imm   = imm;
        iss.pc    = pc;
        iss.rd    = rd;
        return iss;
    endfunction

    task automatic push_entry(input logic is_mul, input exu_issue_t iss, input logic irq,
                              input xdata_t irq_addr, input logic we, input xdata_t wdata,
                              input logic flag, input xdata_t addr);
        tb_entry_t e;
        e.is_mul        = is_mul;
        e.issue         = iss;
        e.irq           = irq;
        e.irq_addr      = irq_addr;
        e.exp_wb.we     = we;
        e.exp_wb.waddr  = iss.rd;
        e.exp_wb.wdata  = wdata;
        e.exp_jump.flag = flag;
        e.exp_jump.addr = addr;
        table_q.push_back(e);
    endtask

    task automatic alu_case(input alu_op_e op, input xdata_t rs1, input xdata_t rs2,
                            input xdata_t imm, input reg_addr_t rd, input xdata_t res);
        push_entry(1'b0, make_issue(CLS_ALU, op, rs1, rs2, imm, 32'h0000_1000, rd),
                   1'b0, '0, 1'b1, res, 1'b0, '0);
    endtask

    // jumps link pc+4, conditional branches write nothing
    task automatic branch_case(input bru_op_e op, input xdata_t rs1, input xdata_t rs2,
                               input xdata_t imm, input xdata_t pc, input logic taken,
                               input xdata_t target);
        logic link;
        link = (op == BRU_JAL || op == BRU_JALR);
        push_entry(1'b0, make_issue(CLS_BRU, 4'(op), rs1, rs2, imm, pc, 5'd20),
                   1'b0, '0, link, pc + 32'd4, taken, target);
    endtask

    task automatic mul_case(input mul_op_e op, input xdata_t a, input xdata_t b,
                            input reg_addr_t rd);
        push_entry(1'b1, make_issue(CLS_MUL, 4'(op), a, b, '0, 32'h0000_2000, rd),
                   1'b0, '0, 1'b1, mul_result(op, a, b), 1'b0, '0);
    endtask

    // no write, redirect to the handler
    task automatic irq_case(input exu_issue_t iss, input xdata_t handler);
        push_entry(1'b0, iss, 1'b1, handler, 1'b0, '0, 1'b1, handler);
    endtask

    task automatic build_table();
        int i;
        alu_case(ALU_ADD,   32'hffff_fff0, 32'h0000_0020, '0, 5'd1, 32'h0000_0010);
        alu_case(ALU_SUB,   32'h0000_0003, 32'h0000_0005, '0, 5'd2, 32'hffff_fffe);
        // shift amount from the low five bits only
        alu_case(ALU_SLL,   32'h0000_0001, 32'h0000_0024, '0, 5'd3, 32'h0000_0010);
        alu_case(ALU_SLT,   32'hffff_ffff, 32'h0000_0001, '0, 5'd4, 32'h0000_0001);
        alu_case(ALU_SLTU,  32'hffff_ffff, 32'h0000_0001, '0, 5'd5, 32'h0000_0000);
        alu_case(ALU_XOR,   32'hf0f0_f0f0, 32'hff00_ff00, '0, 5'd6, 32'h0ff0_0ff0);
        alu_case(ALU_SRL,   32'h8000_0000, 32'h0000_0004, '0, 5'd7, 32'h0800_0000);
        alu_case(ALU_SRA,   32'h8000_0000, 32'h0000_0004, '0, 5'd8, 32'hf800_0000);
        alu_case(ALU_OR,    32'h1200_0034, 32'h0056_7800, '0, 5'd9, 32'h1256_7834);
        alu_case(ALU_AND,   32'hff00_ff00, 32'h0f0f_0f0f, '0, 5'd10, 32'h0f00_0f00);
        alu_case(ALU_LUI,   32'hdead_beef, 32'hdead_beef, 32'h1234_5000, 5'd11, 32'h1234_5000);
        alu_case(ALU_AUIPC, 32'hdead_beef, 32'h0, 32'h0002_0000, 5'd12, 32'h0002_1000);

        branch_case(BRU_BEQ,  32'd5, 32'd5, 32'h40, 32'h100, 1'b1, 32'h140);
        branch_case(BRU_BEQ,  32'd5, 32'd6, 32'h40, 32'h100, 1'b0, 32'h140);
        branch_case(BRU_BNE,  32'd5, 32'd6, 32'h40, 32'h100, 1'b1, 32'h140);
        branch_case(BRU_BLT,  32'hffff_ffff, 32'd1, 32'h40, 32'h100, 1'b1, 32'h140);
        branch_case(BRU_BGE,  32'hffff_ffff, 32'd1, 32'h40, 32'h100, 1'b0, 32'h140);
        branch_case(BRU_BLTU, 32'hffff_ffff, 32'd1, 32'h40, 32'h100, 1'b0, 32'h140);
        branch_case(BRU_BGEU, 32'hffff_ffff, 32'd1, 32'h40, 32'h100, 1'b1, 32'h140);
        branch_case(BRU_JAL,  32'd0, 32'd0, 32'hffff_fff0, 32'h200, 1'b1, 32'h1f0);
        branch_case(BRU_JALR, 32'h301, 32'd0, 32'h10, 32'h400, 1'b1, 32'h310);

        irq_case(make_issue(CLS_ALU, ALU_ADD, 32'd1, 32'd2, '0, 32'h1000, 5'd3), 32'h80);
        irq_case(make_issue(CLS_BRU, 4'(BRU_JAL), '0, '0, 32'h8, 32'h300, 5'd4), 32'h80);
        irq_case(make_issue(CLS_MUL, 4'(MUL_MULHU), 32'd7, 32'd9, '0, 32'h2000, 5'd5),
                 32'h0000_0084);
        // an interrupted multiply must leave hold low on the next cycle
        alu_case(ALU_ADD, 32'd100, 32'd23, '0, 5'd13, 32'd123);

        mul_case(MUL_MUL,    32'h0000_0000, 32'h1234_5678, 5'd21);
        mul_case(MUL_MUL,    32'h8000_0000, 32'hffff_ffff, 5'd22);
        mul_case(MUL_MULH,   32'hffff_ffff, 32'hffff_ffff, 5'd23);
        mul_case(MUL_MULH,   32'h8000_0000, 32'h8000_0000, 5'd24);
        mul_case(MUL_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 5'd25);
        mul_case(MUL_MULHSU, 32'h8000_0000, 32'h0000_0003, 5'd26);
        mul_case(MUL_MULHU,  32'hffff_ffff, 32'hffff_ffff, 5'd27);
        mul_case(MUL_MULHU,  32'h8000_0000, 32'h8000_0000, 5'd28);
        for (i = 0; i < 8; i++) begin
            mul_case(mul_op_e'(next_rand() & 32'h3), next_rand(), next_rand(),
                     reg_addr_t'(i + 1));
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s expected 0x%08h, actual 0x%08h",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_outputs(input tb_entry_t e);
        check_val("wb_o.we", 32'(e.exp_wb.we), 32'(wb_o.we));
        if (e.exp_wb.we) begin
            check_val("wb_o.waddr", 32'(e.exp_wb.waddr), 32'(wb_o.waddr));
            check_val("wb_o.wdata", e.exp_wb.wdata, wb_o.wdata);
        end
        check_val("jump_o.flag", 32'(e.exp_jump.flag), 32'(jump_o.flag));
        if (e.exp_jump.flag) begin
            check_val("jump_o.addr", e.exp_jump.addr, jump_o.addr);
        end
    endtask

    task automatic run_entry(input tb_entry_t e);
        int k;
        @(posedge clk);
        issue_i      <= e.issue;
        int_assert_i <= e.irq;
        int_addr_i   <= e.irq_addr;
        @(negedge clk);
        if (!e.is_mul) begin
            check_outputs(e);
            check_val("hold_o", 32'd0, 32'(hold_o));
        end else begin
            // next rising edge is the start edge
            check_val("hold_o", 32'd0, 32'(hold_o));
            for (k = 0; k <= MUL_STEPS; k++) begin
                @(negedge clk);
                check_val("hold_o", 32'd1, 32'(hold_o));
                check_val("wb_o.we", 32'd0, 32'(wb_o.we));
            end
            // result cycle, MUL_STEPS+1 edges after start
            @(negedge clk);
            check_val("hold_o", 32'd1, 32'(hold_o));
            check_outputs(e);
            @(posedge clk);
            issue_i      <= '0;
            int_assert_i <= 1'b0;
            @(negedge clk);
            check_val("hold_o", 32'd0, 32'(hold_o));
            check_val("wb_o.we", 32'd0, 32'(wb_o.we));
        end
    endtask

    initial begin
        wait (timeout_cycles != 0);
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset_i      = 1'b1;
        issue_i      = '0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        build_table();
        timeout_cycles = table_q.size() * (MUL_STEPS + 4) + 20;

        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_val("wb_o.we", 32'd0, 32'(wb_o.we));
        check_val("jump_o.flag", 32'd0, 32'(jump_o.flag));
        check_val("hold_o", 32'd0, 32'(hold_o));

        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end

        // idle cycle after the last entry
        @(posedge clk);
        issue_i      <= '0;
        int_assert_i <= 1'b0;
        @(negedge clk);
        check_val("hold_o", 32'd0, 32'(hold_o));

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- all.f
hw/rv_isa_pkg.sv
hw/exu_pkg.sv
hw/exu_alu.sv
hw/exu_bru.sv
hw/exu_mul.sv
hw/exu_top.sv
verif/exu_tb.sv

//--- Makefile
# Verilator flow for the execute stage
# usage: make lint | make sim | make clean

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= exu_tb
RTL_TOP   ?= exu_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

RTL_FILES := $(shell grep '^hw/' $(FILELIST))
ALL_FILES := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(ALL_FILES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
sim: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
